//--- hw/prihandler_pkg.sv
// Priority handler shared types and layer ordering
package prihandler_pkg;

    localparam int PIXEL_W     = 4;                    // Tilemap pixel
    localparam int PALETTE_W   = 7;                    // Tile palette field
    localparam int OBJ_PIXEL_W = 8;                    // Sprite pixel
    localparam int CD_W        = PALETTE_W + PIXEL_W;  // Palette code out

    typedef enum logic [1:0] {
        layer_tma = 2'd0,
        layer_tmb = 2'd1,
        layer_obj = 2'd2
    } layer_t;

    // Each name lists its layers front to back
    typedef enum logic [3:0] {
        prm_a, prm_b, prm_o, prm_a_b, prm_a_b_o, prm_a_o, prm_a_o_b, prm_b_a,
        prm_b_a_o, prm_b_o, prm_b_o_a, prm_o_a, prm_o_a_b, prm_o_b, prm_o_b_a
    } prmode_t;

    typedef struct packed {
        logic [3:0]           pr;
        logic                 flip;
        logic [PALETTE_W-1:0] palette;
    } tma_prop_t;

    typedef struct packed {
        logic [1:0]           pr;
        logic                 flip;
        logic [PALETTE_W-1:0] palette;
    } tmb_prop_t;

    typedef struct packed {
        logic [1:0]   len;       // Layers in use
        layer_t [2:0] order;     // order[0] is the front layer
        layer_t       fallback;  // Shown when nothing listed is opaque
    } mode_order_t;

    function automatic mode_order_t make_order(logic [1:0] len, layer_t l0, layer_t l1,
                                               layer_t l2);
        mode_order_t r;
        logic        has_obj;
        r.len      = len;
        r.order[0] = l0;
        r.order[1] = l1;
        r.order[2] = l2;
        has_obj    = 1'b0;
        for (int i = 0; i < 3; i++) begin
            if (i < int'(len) && r.order[i] == layer_obj) has_obj = 1'b1;
        end
        // Object shows through unless tilemap A is the front layer
        r.fallback = (has_obj && l0 != layer_tma) ? layer_obj : l0;
        return r;
    endfunction

    function automatic mode_order_t mode_order(prmode_t mode);
        case (mode)
            prm_b:     return make_order(2'd1, layer_tmb, layer_tmb, layer_tmb);
            prm_o:     return make_order(2'd1, layer_obj, layer_obj, layer_obj);
            prm_a_b:   return make_order(2'd2, layer_tma, layer_tmb, layer_tmb);
            prm_a_b_o: return make_order(2'd3, layer_tma, layer_tmb, layer_obj);
            prm_a_o:   return make_order(2'd2, layer_tma, layer_obj, layer_obj);
            prm_a_o_b: return make_order(2'd3, layer_tma, layer_obj, layer_tmb);
            prm_b_a:   return make_order(2'd2, layer_tmb, layer_tma, layer_tma);
            prm_b_a_o: return make_order(2'd3, layer_tmb, layer_tma, layer_obj);
            prm_b_o:   return make_order(2'd2, layer_tmb, layer_obj, layer_obj);
            prm_b_o_a: return make_order(2'd3, layer_tmb, layer_obj, layer_tma);
            prm_o_a:   return make_order(2'd2, layer_obj, layer_tma, layer_tma);
            prm_o_a_b: return make_order(2'd3, layer_obj, layer_tma, layer_tmb);
            prm_o_b:   return make_order(2'd2, layer_obj, layer_tmb, layer_tmb);
            prm_o_b_a: return make_order(2'd3, layer_obj, layer_tmb, layer_tma);
            default:   return make_order(2'd1, layer_tma, layer_tma, layer_tma);
        endcase
    endfunction

endpackage

//--- hw/property_delay_chain.sv
// Strobe-loaded property delay chain
`timescale 1ns/1ps

module property_delay_chain #(
    parameter int  DEPTH     = 3,
    parameter type payload_t = logic [7:0]
) (
    input  logic             i_EMU_MCLK,
    input  logic             i_reset,
    input  logic             i_clk6m_cen_n,
    input  logic [DEPTH-1:0] i_load_n,     // Bit k loads stage k, active low
    input  payload_t         i_data,
    output payload_t         o_prev,
    output payload_t         o_last
);

    payload_t stage_q  [DEPTH];
    payload_t stage_in [DEPTH];

    assign stage_in[0] = i_data;

    genvar k;
    generate
        for (k = 1; k < DEPTH; k++) begin : g_link
            assign stage_in[k] = stage_q[k-1];  // Previous stage feeds forward
        end
    endgenerate

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_reset) begin
            for (int s = 0; s < DEPTH; s++) begin
                stage_q[s] <= '0;
            end
        end else if (!i_clk6m_cen_n) begin
            for (int s = 0; s < DEPTH; s++) begin
                if (!i_load_n[s]) stage_q[s] <= stage_in[s];
            end
        end
    end

    assign o_last = stage_q[DEPTH-1];
    assign o_prev = stage_q[DEPTH-2];

    // Timing strobes of one chain never overlap
    a_single_load : assert property (@(posedge i_EMU_MCLK) disable iff (i_reset)
        !i_clk6m_cen_n |-> $onehot0(~i_load_n))
        else $error("property chain loads two stages at once");

endmodule

//--- hw/property_shifter.sv
// Tilemap A and B property shifter
`timescale 1ns/1ps

module property_shifter import prihandler_pkg::*; #(
    parameter int TMA_DEPTH = 4,
    parameter int TMB_DEPTH = 3
) (
    input  logic                 i_EMU_MCLK,
    input  logic                 i_reset,
    input  logic                 i_clk6m_cen_n,
    input  logic                 i_abs_n1h,
    input  logic                 i_abs_n2n3h,
    input  logic                 i_abs_n6n7h,
    input  logic                 i_shifta1,
    input  logic                 i_shifta2,
    input  logic                 i_shiftb,
    input  logic [3:0]           i_pr,
    input  logic                 i_vhff,
    input  logic [PALETTE_W-1:0] i_vc,
    output tma_prop_t            o_a_prop,
    output tmb_prop_t            o_b_prop,
    output logic                 o_a_flip,
    output logic                 o_b_flip
);

    logic                 p3_n;      // Pixel 3 strobe
    logic                 p7_n;      // Pixel 7 strobe
    logic [TMA_DEPTH-1:0] a_load_n;
    logic [TMB_DEPTH-1:0] b_load_n;
    tma_prop_t            a_in;
    tmb_prop_t            b_in;
    tma_prop_t            a_prev;

    assign p3_n = i_abs_n2n3h | i_abs_n1h;
    assign p7_n = i_abs_n6n7h | i_abs_n1h;

    ////////////////////////////////////////////////////////////
    // Strobe routing, stage 1 in bit 0

    assign a_load_n = {i_shifta2, i_shifta1, p7_n, p3_n};
    assign b_load_n = {i_shiftb, p3_n, p7_n};

    assign a_in = '{pr: i_pr, flip: i_vhff, palette: i_vc};
    assign b_in = '{pr: i_pr[1:0], flip: i_vhff, palette: i_vc};

    property_delay_chain #(.DEPTH(TMA_DEPTH), .payload_t(tma_prop_t)) tma_chain_i (
        .i_EMU_MCLK   (i_EMU_MCLK),
        .i_reset      (i_reset),
        .i_clk6m_cen_n(i_clk6m_cen_n),
        .i_load_n     (a_load_n),
        .i_data       (a_in),
        .o_prev       (a_prev),
        .o_last       (o_a_prop)
    );

    property_delay_chain #(.DEPTH(TMB_DEPTH), .payload_t(tmb_prop_t)) tmb_chain_i (
        .i_EMU_MCLK   (i_EMU_MCLK),
        .i_reset      (i_reset),
        .i_clk6m_cen_n(i_clk6m_cen_n),
        .i_load_n     (b_load_n),
        .i_data       (b_in),
        .o_prev       (),
        .o_last       (o_b_prop)
    );

    assign o_a_flip = a_prev.flip;    // A stage 3
    assign o_b_flip = o_b_prop.flip;  // B stage 3

endmodule

//--- hw/obj_pixel_latch.sv
// Sprite pixel pair latch
`timescale 1ns/1ps

module obj_pixel_latch import prihandler_pkg::*; (
    input  logic                     i_EMU_MCLK,
    input  logic                     i_reset,
    input  logic                     i_clk6m_cen_n,
    input  logic                     i_abs_n1h,
    input  logic                     i_hflip,
    input  logic [2*OBJ_PIXEL_W-1:0] i_objbuf_data,
    output logic [OBJ_PIXEL_W-1:0]   o_obj_pixel,
    output logic                     o_obj_opaque
);

    logic [OBJ_PIXEL_W-1:0] pix_even_q;
    logic [OBJ_PIXEL_W-1:0] pix_odd_q;
    logic                   sel_odd;

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_reset) begin
            pix_even_q <= '0;
            pix_odd_q  <= '0;
        end else if (!i_clk6m_cen_n && !i_abs_n1h) begin  // Every odd pixel
            pix_odd_q  <= i_objbuf_data[2*OBJ_PIXEL_W-1:OBJ_PIXEL_W];
            pix_even_q <= i_objbuf_data[OBJ_PIXEL_W-1:0];
        end
    end

    // Flip reverses the order inside the pair
    assign sel_odd      = ~i_abs_n1h ^ i_hflip;
    assign o_obj_pixel  = sel_odd ? pix_odd_q : pix_even_q;
    assign o_obj_opaque = |o_obj_pixel[3:0];  // Colour 0 is transparent

endmodule

//--- hw/prmode_decoder.sv
// Priority code decoder
`timescale 1ns/1ps

module prmode_decoder import prihandler_pkg::*; (
    input  logic [3:0] i_a_pr,
    input  logic [1:0] i_b_pr,
    output prmode_t    o_mode
);

    logic [5:0] code;

    assign code = {i_b_pr, i_a_pr};  // B pr high, A pr low

    ////////////////////////////////////////////////////////////
    // Plain ordering modes only

    always_comb begin
        casez (code)
            6'b??_0101:             o_mode = prm_a;
            6'b?1_1101:             o_mode = prm_a_b;
            6'b?1_1111:             o_mode = prm_a_b_o;
            6'b??_0111:             o_mode = prm_a_o;
            6'b10_1111:             o_mode = prm_a_o_b;
            6'b01_00??:             o_mode = prm_b;
            6'b01_10?1:             o_mode = prm_b_a;
            6'b11_10?1:             o_mode = prm_b_a_o;
            6'b11_00??, 6'b11_1000: o_mode = prm_b_o;
            6'b11_1010:             o_mode = prm_b_o_a;
            6'b00_00??, 6'b00_1?00,
            6'b??_0100:             o_mode = prm_o;
            6'b??_0110, 6'b00_1110: o_mode = prm_o_a;
            6'b10_1110:             o_mode = prm_o_a_b;
            6'b10_00??, 6'b10_1000: o_mode = prm_o_b;
            6'b10_1010:             o_mode = prm_o_b_a;
            default:                o_mode = prm_a;  // Unused codes show A
        endcase
    end

endmodule

//--- hw/layer_mixer.sv
// Layer selection and palette code register
`timescale 1ns/1ps

module layer_mixer import prihandler_pkg::*; (
    input  logic                   i_EMU_MCLK,
    input  logic                   i_reset,
    input  logic                   i_clk6m_cen_n,
    input  prmode_t                i_mode,
    input  logic                   i_a_opaque,
    input  logic                   i_b_opaque,
    input  logic                   i_obj_opaque,
    input  logic [PALETTE_W-1:0]   i_a_palette,
    input  logic [PALETTE_W-1:0]   i_b_palette,
    input  logic [PIXEL_W-1:0]     i_a_pixel,
    input  logic [PIXEL_W-1:0]     i_b_pixel,
    input  logic [OBJ_PIXEL_W-1:0] i_obj_pixel,
    output logic [CD_W-1:0]        o_cd
);

    mode_order_t     ord;
    logic [2:0]      opaque;   // Indexed by layer_t
    layer_t          layer;
    logic [CD_W-1:0] cd_next;

    assign ord    = mode_order(i_mode);
    assign opaque = {i_obj_opaque, i_b_opaque, i_a_opaque};

    ////////////////////////////////////////////////////////////
    // Front-most opaque layer wins

    always_comb begin
        layer = ord.fallback;
        for (int i = 2; i >= 0; i--) begin
            if (i < int'(ord.len) && opaque[ord.order[i]]) begin
                layer = ord.order[i];
            end
        end
    end

    always_comb begin
        case (layer)
            layer_tma: cd_next = {i_a_palette, i_a_pixel};
            layer_tmb: cd_next = {i_b_palette, i_b_pixel};
            default:   cd_next = {{(CD_W-OBJ_PIXEL_W){1'b0}}, i_obj_pixel};
        endcase
    end

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_reset) begin
            o_cd <= '0;
        end else if (!i_clk6m_cen_n) begin
            o_cd <= cd_next;
        end
    end

    // Sprite codes land in the low palette bank
    a_obj_bank : assert property (@(posedge i_EMU_MCLK) disable iff (i_reset)
        (!i_clk6m_cen_n && layer == layer_obj) |=> o_cd[CD_W-1:OBJ_PIXEL_W] == '0)
        else $error("object code with nonzero upper bits");

endmodule

//--- hw/prihandler.sv
// Tilemap and sprite priority handler
`timescale 1ns/1ps

module prihandler import prihandler_pkg::*; #(
    parameter int TMA_DEPTH = 4,
    parameter int TMB_DEPTH = 3
) (
    input  logic                     i_EMU_MCLK,
    input  logic                     i_reset,
    input  logic                     i_clk6m_cen_n,
    input  logic                     i_hflip,
    input  logic                     i_shifta1,
    input  logic                     i_shifta2,
    input  logic                     i_shiftb,
    input  logic                     i_abs_n1h,
    input  logic                     i_abs_n6n7h,
    input  logic                     i_abs_n2n3h,
    input  logic [PIXEL_W-1:0]       i_a_pixel,
    input  logic [PIXEL_W-1:0]       i_b_pixel,
    input  logic [2*OBJ_PIXEL_W-1:0] i_objbuf_data,
    input  logic                     i_a_trn_n,    // High when A pixel is opaque
    input  logic                     i_b_trn_n,
    input  logic                     i_vhff,
    input  logic [PALETTE_W-1:0]     i_vc,
    input  logic [3:0]               i_pr,
    output logic                     o_a_flip,
    output logic                     o_b_flip,
    output logic [CD_W-1:0]          o_cd
);

    tma_prop_t              a_prop;
    tmb_prop_t              b_prop;
    logic [OBJ_PIXEL_W-1:0] obj_pixel;
    logic                   obj_opaque;
    prmode_t                mode;

    property_shifter #(.TMA_DEPTH(TMA_DEPTH), .TMB_DEPTH(TMB_DEPTH)) shifter_i (
        .i_EMU_MCLK(i_EMU_MCLK), .i_reset(i_reset), .i_clk6m_cen_n(i_clk6m_cen_n),
        .i_abs_n1h(i_abs_n1h), .i_abs_n2n3h(i_abs_n2n3h), .i_abs_n6n7h(i_abs_n6n7h),
        .i_shifta1(i_shifta1), .i_shifta2(i_shifta2), .i_shiftb(i_shiftb),
        .i_pr(i_pr), .i_vhff(i_vhff), .i_vc(i_vc),
        .o_a_prop(a_prop), .o_b_prop(b_prop),
        .o_a_flip(o_a_flip), .o_b_flip(o_b_flip)
    );

    obj_pixel_latch obj_latch_i (
        .i_EMU_MCLK(i_EMU_MCLK), .i_reset(i_reset), .i_clk6m_cen_n(i_clk6m_cen_n),
        .i_abs_n1h(i_abs_n1h), .i_hflip(i_hflip), .i_objbuf_data(i_objbuf_data),
        .o_obj_pixel(obj_pixel), .o_obj_opaque(obj_opaque)
    );

    prmode_decoder decoder_i (
        .i_a_pr(a_prop.pr), .i_b_pr(b_prop.pr), .o_mode(mode)
    );

    layer_mixer mixer_i (
        .i_EMU_MCLK(i_EMU_MCLK), .i_reset(i_reset), .i_clk6m_cen_n(i_clk6m_cen_n),
        .i_mode(mode),
        .i_a_opaque(i_a_trn_n), .i_b_opaque(i_b_trn_n), .i_obj_opaque(obj_opaque),
        .i_a_palette(a_prop.palette), .i_b_palette(b_prop.palette),
        .i_a_pixel(i_a_pixel), .i_b_pixel(i_b_pixel), .i_obj_pixel(obj_pixel),
        .o_cd(o_cd)
    );

endmodule

//--- bench/tb_prihandler.sv
// Priority handler directed testbench
`timescale 1ns/1ps

module tb_prihandler import prihandler_pkg::*; ();

    logic                     i_EMU_MCLK, i_reset, i_clk6m_cen_n, i_hflip;
    logic                     i_shifta1, i_shifta2, i_shiftb;
    logic                     i_abs_n1h, i_abs_n6n7h, i_abs_n2n3h;
    logic                     i_a_trn_n, i_b_trn_n, i_vhff;
    logic [PIXEL_W-1:0]       i_a_pixel, i_b_pixel;
    logic [2*OBJ_PIXEL_W-1:0] i_objbuf_data;
    logic [PALETTE_W-1:0]     i_vc;
    logic [3:0]               i_pr;
    logic                     o_a_flip, o_b_flip;
    logic [CD_W-1:0]          o_cd;
    integer                   seed = 32'hd9b8_4b08;
    logic [5:0]               cur_code;  // Code held in the chains
    logic [PALETTE_W-1:0]     cur_vc;
    // One code per kept mode, in prmode_t order
    logic [5:0] mode_codes [15] = '{6'b00_0101, 6'b01_0000, 6'b00_0000, 6'b01_1101,
        6'b01_1111, 6'b00_0111, 6'b10_1111, 6'b01_1001, 6'b11_1001, 6'b11_0000,
        6'b11_1010, 6'b00_0110, 6'b10_1110, 6'b10_0000, 6'b10_1010};
    logic [5:0] dropped_codes [4] = '{6'b00_1101, 6'b00_1111, 6'b01_1000, 6'b10_1100};

    prihandler #(.TMA_DEPTH(4), .TMB_DEPTH(3)) dut_i (.*);

    initial begin
        i_EMU_MCLK = 1'b0;
        forever #20 i_EMU_MCLK = ~i_EMU_MCLK;
    end

    ////////////////////////////////////////////////////////////
    // Checking and reference model

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic tick();
        @(posedge i_EMU_MCLK);
    endtask

    // Priority code table, B pr high and A pr low
    function automatic prmode_t decode_code(input logic [5:0] code);
        prmode_t m;
        casez (code)
            6'b??_0101:                         m = prm_a;
            6'b?1_1101:                         m = prm_a_b;
            6'b?1_1111:                         m = prm_a_b_o;
            6'b??_0111:                         m = prm_a_o;
            6'b10_1111:                         m = prm_a_o_b;
            6'b01_00??:                         m = prm_b;
            6'b01_10?1:                         m = prm_b_a;
            6'b11_10?1:                         m = prm_b_a_o;
            6'b11_00??, 6'b11_1000:             m = prm_b_o;
            6'b11_1010:                         m = prm_b_o_a;
            6'b00_00??, 6'b00_1?00, 6'b??_0100: m = prm_o;
            6'b??_0110, 6'b00_1110:             m = prm_o_a;
            6'b10_1110:                         m = prm_o_a_b;
            6'b10_00??, 6'b10_1000:             m = prm_o_b;
            6'b10_1010:                         m = prm_o_b_a;
            default:                            m = prm_a;
        endcase
        return m;
    endfunction

    function automatic logic [CD_W-1:0] expected_cd(input prmode_t m, input logic [2:0] opq,
                                                    input logic [3:0] a_pix,
                                                    input logic [3:0] b_pix,
                                                    input logic [7:0] o_pix);
        mode_order_t ord;
        layer_t      pick;
        logic        found;
        ord   = mode_order(m);
        pick  = ord.fallback;
        found = 1'b0;
        for (int i = 0; i < int'(ord.len); i++) begin
            if (!found && opq[int'(ord.order[i])]) begin  // Front-most opaque
                pick  = ord.order[i];
                found = 1'b1;
            end
        end
        case (pick)
            layer_tma: return {cur_vc, a_pix};
            layer_tmb: return {cur_vc, b_pix};
            default:   return {3'b000, o_pix};
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus

    // Strobe order p3, p7, p3, p7, shifta1, shifta2, shiftb
    task automatic load_props(input logic [5:0] code, input logic vhff, input logic [6:0] vc);
        for (int s = 0; s < 8; s++) begin
            tick();
            i_vhff      <= vhff;
            i_vc        <= vc;
            i_pr        <= s[0] ? {2'b00, code[5:4]} : code[3:0];  // B samples on p7
            i_abs_n1h   <= (s >= 4);
            i_abs_n2n3h <= !(s == 0 || s == 2);
            i_abs_n6n7h <= !(s == 1 || s == 3);
            i_shifta1   <= (s != 4);
            i_shifta2   <= (s != 5);
            i_shiftb    <= (s != 6);
        end
        cur_code = code;
        cur_vc   = vc;
    endtask

    // Latch a sprite pair, then o_cd registers the chosen layer
    task automatic show_check(input logic a_op, input logic b_op, input logic [15:0] data,
                              input logic phase, input logic hf);
        logic [31:0] r;
        logic [7:0]  o_pix;
        r     = $random(seed);
        o_pix = (~phase ^ hf) ? data[15:8] : data[7:0];
        tick();
        i_objbuf_data <= data;
        i_abs_n1h     <= 1'b0;
        i_hflip       <= hf;
        i_a_trn_n     <= a_op;
        i_b_trn_n     <= b_op;
        i_a_pixel     <= r[3:0];
        i_b_pixel     <= r[7:4];
        tick();
        i_abs_n1h <= phase;
        tick();
        @(negedge i_EMU_MCLK);
        check_eq("o_cd", 32'(o_cd), 32'(expected_cd(decode_code(cur_code),
                 {|o_pix[3:0], b_op, a_op}, r[3:0], r[7:4], o_pix)));
    endtask

    task automatic sweep_opaque(input logic [5:0] code);
        logic [31:0] r;
        r = $random(seed);
        load_props(code, r[7], r[6:0]);
        for (int op = 0; op < 8; op++) begin
            r = $random(seed);
            show_check(op[0], op[1], op[2] ? (r[15:0] | 16'h0001) : (r[15:0] & 16'hfff0),
                       1'b1, 1'b0);
        end
    endtask

    initial begin
        logic [31:0]     r;
        logic [5:0]      code;
        logic [CD_W-1:0] held_cd;
        logic            held_a;
        logic            held_b;
        i_reset       = 1'b1;
        i_clk6m_cen_n = 1'b0;
        i_hflip       = 1'b0;
        i_shifta1     = 1'b1;
        i_shifta2     = 1'b1;
        i_shiftb      = 1'b1;
        i_abs_n1h     = 1'b1;
        i_abs_n6n7h   = 1'b1;
        i_abs_n2n3h   = 1'b1;
        i_a_pixel     = '0;
        i_b_pixel     = '0;
        i_objbuf_data = '0;
        i_a_trn_n     = 1'b0;
        i_b_trn_n     = 1'b0;
        i_vhff        = 1'b0;
        i_vc          = '0;
        i_pr          = '0;
        cur_code      = '0;
        cur_vc        = '0;
        repeat (5) tick();
        i_reset <= 1'b0;
        @(negedge i_EMU_MCLK);
        check_eq("o_cd", 32'(o_cd), 32'(0));
        check_eq("o_a_flip", 32'(o_a_flip), 32'(0));
        check_eq("o_b_flip", 32'(o_b_flip), 32'(0));
        show_check(1'b0, 1'b0, 16'h5a3c, 1'b1, 1'b0);  // Mode o after reset
        for (int i = 0; i < 4; i++) begin
            r    = $random(seed);
            code = (i < 2) ? mode_codes[i] : r[13:8];
            load_props(code, r[7], r[6:0]);
            @(negedge i_EMU_MCLK);
            check_eq("o_a_flip", 32'(o_a_flip), 32'(r[7]));
            check_eq("o_b_flip", 32'(o_b_flip), 32'(r[7]));
            show_check(1'b1, 1'b1, 16'h0000, 1'b1, 1'b0);
        end
        load_props(mode_codes[int'(prm_o_a)], 1'b0, 7'h2a);
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            show_check(1'b1, 1'b0, i[2] ? (r[15:0] & 16'hf0f0) : r[15:0], i[1], i[0]);
        end
        for (int m = 0; m < 15; m++) sweep_opaque(mode_codes[m]);
        for (int d = 0; d < 4; d++) sweep_opaque(dropped_codes[d]);
        held_cd = o_cd;
        held_a  = o_a_flip;
        held_b  = o_b_flip;
        tick();
        i_clk6m_cen_n <= 1'b1;  // Freeze everything
        i_a_pixel     <= ~i_a_pixel;
        i_b_pixel     <= ~i_b_pixel;
        i_a_trn_n     <= ~i_a_trn_n;
        i_objbuf_data <= ~i_objbuf_data;
        load_props(cur_code, ~held_a, ~cur_vc);  // Full strobe run with new flip
        @(negedge i_EMU_MCLK);
        check_eq("o_cd", 32'(o_cd), 32'(held_cd));
        check_eq("o_a_flip", 32'(o_a_flip), 32'(held_a));
        check_eq("o_b_flip", 32'(o_b_flip), 32'(held_b));
        $display("All checks passed");
        $finish;
    end

endmodule

//--- all.f
hw/prihandler_pkg.sv
hw/property_delay_chain.sv
hw/property_shifter.sv
hw/obj_pixel_latch.sv
hw/prmode_decoder.sv
hw/layer_mixer.sv
hw/prihandler.sv
bench/tb_prihandler.sv

//--- Makefile
SRCS := $(shell cat all.f)

.PHONY: run clean

obj_dir/Vtb_prihandler: all.f $(SRCS)
	verilator --binary --assert --top-module tb_prihandler -f all.f

run: obj_dir/Vtb_prihandler
	@out="$$(./obj_dir/Vtb_prihandler 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
